//--- verilog/ccc_target_pkg.sv
`default_nettype none

package ccc_target_pkg;

  typedef enum logic {
    RX_ZERO_PRE = 1'b0,  // Single 0 preamble bit
    RX_BYTE     = 1'b1   // Eight data bits plus odd parity
  } rx_mode_e;

  typedef enum logic {
    TX_ONE_PRE = 1'b0,  // Single 1 acknowledge bit
    TX_BYTE    = 1'b1   // Eight data bits plus odd parity
  } tx_mode_e;

  // Broadcast codes
  localparam logic [7:0] CCC_ENEC_BC       = 8'h00;
  localparam logic [7:0] CCC_DISEC_BC      = 8'h01;
  localparam logic [7:0] CCC_SETMWL_BC     = 8'h09;
  localparam logic [7:0] CCC_SETMRL_BC     = 8'h0A;
  localparam logic [7:0] CCC_RSTACT_BC     = 8'h2A;
  // Direct codes
  localparam logic [7:0] CCC_ENEC_DIR      = 8'h80;
  localparam logic [7:0] CCC_DISEC_DIR     = 8'h81;
  localparam logic [7:0] CCC_SETMWL_DIR    = 8'h89;
  localparam logic [7:0] CCC_SETMRL_DIR    = 8'h8A;
  localparam logic [7:0] CCC_GETMWL_DIR    = 8'h8B;
  localparam logic [7:0] CCC_GETMRL_DIR    = 8'h8C;
  localparam logic [7:0] CCC_GETPID_DIR    = 8'h8D;
  localparam logic [7:0] CCC_GETBCR_DIR    = 8'h8E;
  localparam logic [7:0] CCC_GETDCR_DIR    = 8'h8F;
  localparam logic [7:0] CCC_GETSTATUS_DIR = 8'h90;
  localparam logic [7:0] CCC_RSTACT_DIR    = 8'h9A;

  localparam int STATUS_PROTO_ERR_BIT = 5;  // Sticky error in status low byte

  // Multi-byte fields are consecutive with high byte first
  typedef enum logic [4:0] {
    REGF_MWL_H    = 5'd0,
    REGF_MWL_L    = 5'd1,
    REGF_MRL_H    = 5'd2,
    REGF_MRL_L    = 5'd3,
    REGF_EVENT_EN = 5'd4,
    REGF_STATUS_H = 5'd5,
    REGF_STATUS_L = 5'd6,
    REGF_RSTACT   = 5'd7,
    REGF_PID0     = 5'd8,   // Most significant PID byte
    REGF_PID1     = 5'd9,
    REGF_PID2     = 5'd10,
    REGF_PID3     = 5'd11,
    REGF_PID4     = 5'd12,
    REGF_PID5     = 5'd13,
    REGF_BCR      = 5'd14,
    REGF_DCR      = 5'd15
  } regf_addr_e;

  typedef struct packed {
    logic       wr;     // Write strobe
    logic       rd;     // Read level
    regf_addr_e addr;
    logic [7:0] wdata;
  } regf_req_t;

  typedef struct packed {
    logic [7:0] ccc;  // Code of the command
    logic       ok;
    logic       nack;  // Unsupported code
    logic       err;   // Preamble or parity failure
  } ccc_result_t;

endpackage

`default_nettype wire

//--- verilog/ccc_target_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ccc_target_ctrl import ccc_target_pkg::*; (
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  logic        i_engine_en,
  input  logic        i_rx_done,
  input  logic        i_rx_error,
  input  logic [7:0]  i_rx_byte,
  input  logic        i_tx_done,
  output logic        o_rx_en,
  output rx_mode_e    o_rx_mode,
  output logic        o_tx_start,
  output tx_mode_e    o_tx_mode,
  output regf_req_t   o_regf_req,
  output logic        o_engine_done,
  output ccc_result_t o_ccc_result
);

  typedef enum logic [2:0] {
    S_IDLE, S_PRE, S_ACK, S_CMD, S_DECODE, S_RX, S_TX, S_FINISH
  } state_e;

  state_e     state_q, state_d;
  logic [7:0] ccc_q;                  // Current command code
  regf_addr_e addr_q;                 // Address of byte in flight
  logic [2:0] cnt_q;                  // Bytes already handled
  logic [2:0] len_q;                  // Payload length of command
  logic       ok_q, nack_q, err_q;    // Result flags
  logic       fin_ok, fin_nack, fin_err;

  logic [7:0] lut_code;               // Incoming byte while in command phase
  logic       lut_ok;                 // Code is supported
  logic       lut_get;                // Target sends payload
  logic [2:0] lut_len;
  regf_addr_e lut_addr;
  logic       last_byte;

  assign lut_code = (state_q == S_CMD) ? i_rx_byte : ccc_q;

  // Per-code payload description
  always_comb begin
    lut_ok   = 1'b1;
    lut_get  = 1'b0;
    lut_len  = 3'd1;
    lut_addr = REGF_EVENT_EN;
    case (lut_code)
      CCC_ENEC_BC, CCC_ENEC_DIR,
      CCC_DISEC_BC, CCC_DISEC_DIR: lut_addr = REGF_EVENT_EN;  // One mask byte
      CCC_SETMWL_BC, CCC_SETMWL_DIR: begin
        lut_len  = 3'd2;
        lut_addr = REGF_MWL_H;
      end
      CCC_SETMRL_BC, CCC_SETMRL_DIR: begin
        lut_len  = 3'd2;
        lut_addr = REGF_MRL_H;
      end
      CCC_RSTACT_BC, CCC_RSTACT_DIR: lut_addr = REGF_RSTACT;  // Defining byte
      CCC_GETMWL_DIR: begin
        lut_get  = 1'b1;
        lut_len  = 3'd2;
        lut_addr = REGF_MWL_H;
      end
      CCC_GETMRL_DIR: begin
        lut_get  = 1'b1;
        lut_len  = 3'd2;
        lut_addr = REGF_MRL_H;
      end
      CCC_GETSTATUS_DIR: begin
        lut_get  = 1'b1;
        lut_len  = 3'd2;
        lut_addr = REGF_STATUS_H;
      end
      CCC_GETPID_DIR: begin
        lut_get  = 1'b1;
        lut_len  = 3'd6;               // PID0 up to PID5
        lut_addr = REGF_PID0;
      end
      CCC_GETBCR_DIR: begin
        lut_get  = 1'b1;
        lut_addr = REGF_BCR;
      end
      CCC_GETDCR_DIR: begin
        lut_get  = 1'b1;
        lut_addr = REGF_DCR;
      end
      default: lut_ok = 1'b0;          // Ends in NACK
    endcase
  end

  assign last_byte = (cnt_q == len_q - 3'd1);

  always_comb begin
    state_d    = state_q;
    o_rx_en    = 1'b0;
    o_rx_mode  = RX_BYTE;
    o_tx_start = 1'b0;
    o_tx_mode  = TX_BYTE;
    o_regf_req = '0;
    fin_ok     = 1'b0;
    fin_nack   = 1'b0;
    fin_err    = 1'b0;
    if (!i_engine_en && state_q != S_IDLE && state_q != S_FINISH) begin
      state_d = S_IDLE;                // Abort without done pulse
    end else begin
      case (state_q)
        S_IDLE: if (i_engine_en) state_d = S_PRE;
        S_PRE: begin
          o_rx_en   = 1'b1;
          o_rx_mode = RX_ZERO_PRE;
          if (i_rx_done) begin
            state_d    = S_ACK;
            o_tx_start = 1'b1;         // Answer with 1 preamble
            o_tx_mode  = TX_ONE_PRE;
          end else if (i_rx_error) begin
            state_d = S_FINISH;
            fin_err = 1'b1;
          end
        end
        S_ACK: if (i_tx_done) state_d = S_CMD;
        S_CMD: begin
          o_rx_en = 1'b1;
          if (i_rx_done) begin
            if (!lut_ok) begin
              state_d  = S_FINISH;     // Unsupported code
              fin_nack = 1'b1;
            end else begin
              state_d = S_DECODE;
            end
          end else if (i_rx_error) begin
            state_d = S_FINISH;        // Bad CCC parity
            fin_err = 1'b1;
          end
        end
        S_DECODE: begin
          if (lut_get) begin
            state_d         = S_TX;
            o_tx_start      = 1'b1;    // First byte from start address
            o_regf_req.rd   = 1'b1;
            o_regf_req.addr = lut_addr;
          end else begin
            state_d = S_RX;
          end
        end
        S_RX: begin
          o_rx_en = 1'b1;
          if (i_rx_done) begin
            o_regf_req.wr    = 1'b1;
            o_regf_req.addr  = addr_q;
            o_regf_req.wdata = i_rx_byte;
            if (last_byte) begin
              state_d = S_FINISH;
              fin_ok  = 1'b1;
            end
          end else if (i_rx_error) begin
            state_d = S_FINISH;
            fin_err = 1'b1;
          end
        end
        S_TX: begin
          if (i_tx_done) begin
            if (last_byte) begin
              state_d = S_FINISH;
              fin_ok  = 1'b1;
            end else begin
              o_tx_start      = 1'b1;  // Next register byte
              o_regf_req.rd   = 1'b1;
              o_regf_req.addr = regf_addr_e'(addr_q + 5'd1);
            end
          end
        end
        S_FINISH: state_d = S_IDLE;    // Done pulse cycle
        default:  state_d = S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q <= S_IDLE;
      ccc_q   <= 8'h00;
      addr_q  <= REGF_MWL_H;
      cnt_q   <= 3'd0;
      len_q   <= 3'd1;
      ok_q    <= 1'b0;
      nack_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == S_CMD && (i_rx_done || i_rx_error)) ccc_q <= i_rx_byte;
      if (state_q == S_DECODE) begin
        addr_q <= lut_addr;
        len_q  <= lut_len;
        cnt_q  <= 3'd0;
      end else if (o_regf_req.wr || (state_q == S_TX && o_tx_start)) begin
        addr_q <= regf_addr_e'(addr_q + 5'd1);  // Step per byte
        cnt_q  <= cnt_q + 3'd1;
      end
      if (state_d == S_FINISH) begin
        ok_q   <= fin_ok;
        nack_q <= fin_nack;
        err_q  <= fin_err;
      end
    end
  end

  assign o_engine_done = (state_q == S_FINISH);
  assign o_ccc_result  = '{ccc: ccc_q, ok: ok_q, nack: nack_q, err: err_q};

endmodule

`default_nettype wire

//--- verilog/ccc_rx_deframer.sv
`timescale 1ns/100ps
`default_nettype none

module ccc_rx_deframer import ccc_target_pkg::*; (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_rx_en,
  input  rx_mode_e   i_rx_mode,
  input  logic       i_bit_stb,
  input  logic       i_bit_data,
  output logic       o_rx_done,
  output logic       o_rx_error,
  output logic [7:0] o_rx_byte
);

  logic [7:0] shift_q;   // Data bits, MSB first
  logic [3:0] cnt_q;     // Bits taken of current byte
  logic       par_q;     // Running XOR of data bits
  logic       done_q, err_q;
  logic       par_bit;   // Ninth bit of a byte

  assign par_bit = (i_rx_mode == RX_BYTE) && (cnt_q == 4'd8);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      cnt_q  <= 4'd0;
      par_q  <= 1'b0;
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      if (!i_rx_en) begin
        cnt_q <= 4'd0;                 // Restart between phases
        par_q <= 1'b0;
      end else if (i_bit_stb) begin
        if (i_rx_mode == RX_ZERO_PRE) begin
          done_q <= ~i_bit_data;       // Preamble must be 0
          err_q  <= i_bit_data;
        end else if (par_bit) begin
          cnt_q  <= 4'd0;
          par_q  <= 1'b0;
          done_q <= par_q ^ i_bit_data;   // Odd over nine bits
          err_q  <= ~(par_q ^ i_bit_data);
        end else begin
          cnt_q <= cnt_q + 4'd1;
          par_q <= par_q ^ i_bit_data;
        end
      end
    end
  end

  // Parity bit is not shifted in
  always_ff @(posedge i_sys_clk) begin
    if (i_rx_en && i_bit_stb && i_rx_mode == RX_BYTE && !par_bit) begin
      shift_q <= {shift_q[6:0], i_bit_data};
    end
  end

  assign o_rx_done  = done_q;
  assign o_rx_error = err_q;
  assign o_rx_byte  = shift_q;

endmodule

`default_nettype wire

//--- verilog/ccc_tx_framer.sv
`timescale 1ns/100ps
`default_nettype none

module ccc_tx_framer import ccc_target_pkg::*; (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_tx_start,
  input  tx_mode_e   i_tx_mode,
  input  logic [7:0] i_tx_byte,
  input  logic       i_bit_stb,
  output logic       o_sda_out,
  output logic       o_sda_oe,
  output logic       o_tx_done
);

  logic [8:0] shreg_q;   // Bit on SDA is the MSB
  logic [3:0] left_q;    // Bits still to send
  logic       busy_q;
  logic       done_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      left_q <= 4'd0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_tx_start) begin
        busy_q <= 1'b1;
        left_q <= (i_tx_mode == TX_BYTE) ? 4'd9 : 4'd1;
      end else if (busy_q && i_bit_stb) begin
        left_q <= left_q - 4'd1;       // Master sampled current bit
        if (left_q == 4'd1) begin
          busy_q <= 1'b0;              // Release SDA with done
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_tx_start) begin
      if (i_tx_mode == TX_BYTE) begin
        shreg_q <= {i_tx_byte, ~^i_tx_byte};  // Odd parity appended
      end else begin
        shreg_q <= 9'h100;             // Lone 1 preamble
      end
    end else if (busy_q && i_bit_stb) begin
      shreg_q <= {shreg_q[7:0], 1'b0};
    end
  end

  assign o_sda_out = shreg_q[8];
  assign o_sda_oe  = busy_q;
  assign o_tx_done = done_q;

endmodule

`default_nettype wire

//--- verilog/ccc_target_regf.sv
`timescale 1ns/100ps
`default_nettype none

module ccc_target_regf import ccc_target_pkg::*; #(
  parameter logic [15:0] MWL_RESET = 16'h0100,
  parameter logic [15:0] MRL_RESET = 16'h0100,
  parameter logic [47:0] PID       = 48'h0000_0000_0000,
  parameter logic [7:0]  BCR       = 8'h00,
  parameter logic [7:0]  DCR       = 8'h00
) (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  regf_req_t  i_req,
  input  logic       i_proto_err,
  input  logic [7:0] i_ccc,
  output logic [7:0] o_rdata,
  output logic [3:0] o_event_en,
  output logic [7:0] o_rstact_def
);

  logic [15:0] mwl_q;
  logic [15:0] mrl_q;
  logic [3:0]  event_en_q;
  logic        proto_err_q;   // Sticky until status read
  logic [7:0]  rstact_q;
  logic        is_enec, is_disec;

  assign is_enec  = (i_ccc == CCC_ENEC_BC)  || (i_ccc == CCC_ENEC_DIR);
  assign is_disec = (i_ccc == CCC_DISEC_BC) || (i_ccc == CCC_DISEC_DIR);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      mwl_q       <= MWL_RESET;
      mrl_q       <= MRL_RESET;
      event_en_q  <= 4'hF;             // All events enabled
      proto_err_q <= 1'b0;
      rstact_q    <= 8'h00;
    end else begin
      if (i_req.wr) begin
        case (i_req.addr)
          REGF_MWL_H: mwl_q[15:8] <= i_req.wdata;
          REGF_MWL_L: mwl_q[7:0]  <= i_req.wdata;
          REGF_MRL_H: mrl_q[15:8] <= i_req.wdata;
          REGF_MRL_L: mrl_q[7:0]  <= i_req.wdata;
          REGF_EVENT_EN: begin
            if (is_enec)  event_en_q <= event_en_q | i_req.wdata[3:0];   // Set mask
            if (is_disec) event_en_q <= event_en_q & ~i_req.wdata[3:0];  // Clear mask
          end
          REGF_RSTACT: rstact_q <= i_req.wdata;
          default: ;                   // Read-only bytes
        endcase
      end
      // New error wins over clear
      if (i_proto_err) begin
        proto_err_q <= 1'b1;
      end else if (i_req.rd && i_req.addr == REGF_STATUS_L) begin
        proto_err_q <= 1'b0;
      end
    end
  end

  always_comb begin
    o_rdata = 8'h00;
    case (i_req.addr)
      REGF_MWL_H:    o_rdata = mwl_q[15:8];
      REGF_MWL_L:    o_rdata = mwl_q[7:0];
      REGF_MRL_H:    o_rdata = mrl_q[15:8];
      REGF_MRL_L:    o_rdata = mrl_q[7:0];
      REGF_EVENT_EN: o_rdata = {4'h0, event_en_q};
      REGF_STATUS_H: o_rdata = 8'h00;
      REGF_STATUS_L: o_rdata[STATUS_PROTO_ERR_BIT] = proto_err_q;
      REGF_RSTACT:   o_rdata = rstact_q;
      REGF_PID0:     o_rdata = PID[47:40];
      REGF_PID1:     o_rdata = PID[39:32];
      REGF_PID2:     o_rdata = PID[31:24];
      REGF_PID3:     o_rdata = PID[23:16];
      REGF_PID4:     o_rdata = PID[15:8];
      REGF_PID5:     o_rdata = PID[7:0];
      REGF_BCR:      o_rdata = BCR;
      REGF_DCR:      o_rdata = DCR;
      default:       o_rdata = 8'h00;
    endcase
  end

  assign o_event_en   = event_en_q;
  assign o_rstact_def = rstact_q;

endmodule

`default_nettype wire

//--- verilog/ccc_target_top.sv
`timescale 1ns/100ps
`default_nettype none

module ccc_target_top import ccc_target_pkg::*; #(
  parameter logic [15:0] MWL_RESET = 16'h0100,
  parameter logic [15:0] MRL_RESET = 16'h0100,
  parameter logic [47:0] PID       = 48'h0000_0000_0000,
  parameter logic [7:0]  BCR       = 8'h00,
  parameter logic [7:0]  DCR       = 8'h00
) (
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  logic        i_engine_en,
  input  logic        i_bit_stb,
  input  logic        i_bit_data,
  output logic        o_sda_out,
  output logic        o_sda_oe,
  output logic        o_engine_done,
  output ccc_result_t o_ccc_result,
  output logic [3:0]  o_event_en,
  output logic [7:0]  o_rstact_def
);

  logic       rx_en;
  rx_mode_e   rx_mode;
  logic       rx_done;
  logic       rx_error;        // Also sets sticky status bit
  logic [7:0] rx_byte;
  logic       tx_start;
  tx_mode_e   tx_mode;
  logic       tx_done;
  regf_req_t  regf_req;
  logic [7:0] regf_rdata;      // Feeds framer byte directly

  ccc_target_ctrl u_ctrl (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_rx_done     (rx_done),
    .i_rx_error    (rx_error),
    .i_rx_byte     (rx_byte),
    .i_tx_done     (tx_done),
    .o_rx_en       (rx_en),
    .o_rx_mode     (rx_mode),
    .o_tx_start    (tx_start),
    .o_tx_mode     (tx_mode),
    .o_regf_req    (regf_req),
    .o_engine_done (o_engine_done),
    .o_ccc_result  (o_ccc_result)
  );

  ccc_rx_deframer u_rx (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst  (i_sys_rst),
    .i_rx_en    (rx_en),
    .i_rx_mode  (rx_mode),
    .i_bit_stb  (i_bit_stb),
    .i_bit_data (i_bit_data),
    .o_rx_done  (rx_done),
    .o_rx_error (rx_error),
    .o_rx_byte  (rx_byte)
  );

  ccc_tx_framer u_tx (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst  (i_sys_rst),
    .i_tx_start (tx_start),
    .i_tx_mode  (tx_mode),
    .i_tx_byte  (regf_rdata),
    .i_bit_stb  (i_bit_stb),
    .o_sda_out  (o_sda_out),
    .o_sda_oe   (o_sda_oe),
    .o_tx_done  (tx_done)
  );

  ccc_target_regf #(
    .MWL_RESET (MWL_RESET),
    .MRL_RESET (MRL_RESET),
    .PID       (PID),
    .BCR       (BCR),
    .DCR       (DCR)
  ) u_regf (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_req        (regf_req),
    .i_proto_err  (rx_error),
    .i_ccc        (o_ccc_result.ccc),  // Live code selects ENEC or DISEC
    .o_rdata      (regf_rdata),
    .o_event_en   (o_event_en),
    .o_rstact_def (o_rstact_def)
  );

endmodule

`default_nettype wire

//--- tests/ccc_target_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module ccc_target_asserts import ccc_target_pkg::*; (
  input logic      i_sys_clk,
  input logic      i_sys_rst,
  input logic      i_rx_en,       // Deframer enable from controller
  input logic      i_sda_oe,
  input logic      i_engine_done,
  input regf_req_t i_regf_req
);

  // Done is a single-cycle pulse
  done_pulse_a: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst) i_engine_done |=> !i_engine_done
  ) else $error("o_engine_done stayed high for more than one cycle");

  // Target never drives SDA while it listens
  sda_turnaround_a: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst) !(i_sda_oe && i_rx_en)
  ) else $error("o_sda_oe high while the deframer is enabled");

  regf_access_a: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst) !(i_regf_req.wr && i_regf_req.rd)
  ) else $error("register file write and read active in the same cycle");

  // SDA released in reset and on leaving it
  reset_oe_a: assert property (
    @(posedge i_sys_clk) (!i_sys_rst || $rose(i_sys_rst)) |-> !i_sda_oe
  ) else $error("o_sda_oe not low around reset");

endmodule

`default_nettype wire

//--- tests/tb_ccc_target_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ccc_target_top import ccc_target_pkg::*; ();

  localparam logic [15:0] MWL_VAL = 16'h0240;
  localparam logic [15:0] MRL_VAL = 16'h0123;
  localparam logic [47:0] PID_VAL = 48'h5A31_0200_77C4;
  localparam logic [7:0]  BCR_VAL = 8'h66;
  localparam logic [7:0]  DCR_VAL = 8'hC3;
  localparam int          DONE_TIMEOUT = 50;   // Cycles after last strobe

  logic        sys_clk, sys_rst, engine_en, bit_stb, bit_data;
  logic        sda_out, sda_oe, engine_done;
  ccc_result_t ccc_result;
  logic [3:0]  event_en;
  logic [7:0]  rstact_def;

  int          errors, err_mark, tests_run, tests_failed;
  logic [7:0]  wr_bytes [6];     // Payload the master sends
  logic [7:0]  rd_bytes [6];     // Bytes the master read back
  ccc_result_t res;              // Result caught at done
  logic        got_done;

  // Register file reference model
  logic [15:0] ref_mwl, ref_mrl;
  logic [3:0]  ref_event_en;
  logic        ref_err;          // Sticky protocol error
  logic [7:0]  ref_rstact;

  ccc_target_top #(
    .MWL_RESET (MWL_VAL),
    .MRL_RESET (MRL_VAL),
    .PID       (PID_VAL),
    .BCR       (BCR_VAL),
    .DCR       (DCR_VAL)
  ) u_dut (
    .i_sys_clk     (sys_clk),
    .i_sys_rst     (sys_rst),
    .i_engine_en   (engine_en),
    .i_bit_stb     (bit_stb),
    .i_bit_data    (bit_data),
    .o_sda_out     (sda_out),
    .o_sda_oe      (sda_oe),
    .o_engine_done (engine_done),
    .o_ccc_result  (ccc_result),
    .o_event_en    (event_en),
    .o_rstact_def  (rstact_def)
  );

  bind ccc_target_top ccc_target_asserts u_asserts (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_rx_en       (rx_en),
    .i_sda_oe      (o_sda_oe),
    .i_engine_done (o_engine_done),
    .i_regf_req    (regf_req)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;   // 4 ns period
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // One bus bit with SDA sampled just before the strobe edge
  task automatic bus_bit(input logic b, output logic sda, output logic oe);
    int gap;
    gap = 4 + int'($urandom % 6);    // 4 to 9 idle cycles
    repeat (gap) @(posedge sys_clk);
    #1;
    sda      = sda_out;
    oe       = sda_oe;
    bit_stb  = 1'b1;
    bit_data = b;
    @(posedge sys_clk);
    #1;
    bit_stb  = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b, input logic bad_par);
    logic sda, oe;
    for (int i = 7; i >= 0; i--) bus_bit(b[i], sda, oe);   // MSB first
    bus_bit(~^b ^ bad_par, sda, oe);   // Odd parity unless corrupted
  endtask

  task automatic read_byte(output logic [7:0] b);
    logic sda, oe;
    logic par, all_oe;
    par    = 1'b0;
    all_oe = 1'b1;
    for (int i = 7; i >= 0; i--) begin
      bus_bit(1'b1, sda, oe);        // Master leaves SDA released
      b[i]   = sda;
      par    = par ^ sda;
      all_oe = all_oe & oe;
    end
    bus_bit(1'b1, sda, oe);          // Parity bit
    check_val("o_sda_out parity", 32'(par ^ sda), 32'h1);
    check_val("o_sda_oe", 32'(all_oe & oe), 32'h1);
  endtask

  task automatic wait_done();
    int cnt;
    got_done = 1'b0;
    cnt      = 0;
    while (!got_done && cnt < DONE_TIMEOUT) begin
      @(posedge sys_clk);
      #1;
      if (engine_done) begin
        got_done = 1'b1;
        res      = ccc_result;       // Valid in the done cycle
      end
      cnt++;
    end
    if (!got_done) begin
      $display("Timed out waiting for the engine done pulse");
      errors++;
    end
  endtask

  // Preamble, acknowledge, CCC byte, then payload in either direction
  task automatic run_ccc(input logic [7:0] code, input logic bad_par, input int n_wr,
                         input int n_rd);
    logic sda, oe;
    engine_en = 1'b1;
    bus_bit(1'b0, sda, oe);          // Zero preamble
    bus_bit(1'b1, sda, oe);          // Target answers with 1
    check_val("o_sda_out ack", 32'(sda & oe), 32'h1);
    send_byte(code, bad_par);
    for (int i = 0; i < n_wr; i++) send_byte(wr_bytes[i], 1'b0);
    for (int i = 0; i < n_rd; i++) read_byte(rd_bytes[i]);
    wait_done();
    engine_en = 1'b0;                // Back to idle between commands
    @(posedge sys_clk);
    #1;
  endtask

  task automatic check_result(input logic [7:0] code, input logic ok, input logic nack,
                              input logic err);
    check_val("o_engine_done", 32'(got_done), 32'h1);
    if (!err) check_val("o_ccc_result.ccc", 32'(res.ccc), 32'(code));
    check_val("o_ccc_result flags", 32'({res.ok, res.nack, res.err}), 32'({ok, nack, err}));
  endtask

  task automatic set_word(input logic [7:0] code, input logic [15:0] val);
    wr_bytes[0] = val[15:8];         // High byte first
    wr_bytes[1] = val[7:0];
    run_ccc(code, 1'b0, 2, 0);
    check_result(code, 1'b1, 1'b0, 1'b0);
    if (code == CCC_SETMWL_BC || code == CCC_SETMWL_DIR) ref_mwl = val;
    else ref_mrl = val;
  endtask

  task automatic event_cmd(input logic [7:0] code, input logic [7:0] mask);
    wr_bytes[0] = mask;
    run_ccc(code, 1'b0, 1, 0);
    check_result(code, 1'b1, 1'b0, 1'b0);
    if (code == CCC_ENEC_BC || code == CCC_ENEC_DIR) ref_event_en = ref_event_en | mask[3:0];
    else ref_event_en = ref_event_en & ~mask[3:0];
    check_val("o_event_en", 32'(event_en), 32'(ref_event_en));
  endtask

  task automatic rstact_cmd(input logic [7:0] code, input logic [7:0] val);
    wr_bytes[0] = val;
    run_ccc(code, 1'b0, 1, 0);
    check_result(code, 1'b1, 1'b0, 1'b0);
    ref_rstact = val;
    check_val("o_rstact_def", 32'(rstact_def), 32'(ref_rstact));
  endtask

  // GET command checked against the reference model
  task automatic get_check(input logic [7:0] code);
    logic [7:0] exp_b [6];
    int         n;
    n = 1;
    case (code)
      CCC_GETMWL_DIR: begin
        n        = 2;
        exp_b[0] = ref_mwl[15:8];
        exp_b[1] = ref_mwl[7:0];
      end
      CCC_GETMRL_DIR: begin
        n        = 2;
        exp_b[0] = ref_mrl[15:8];
        exp_b[1] = ref_mrl[7:0];
      end
      CCC_GETSTATUS_DIR: begin
        n        = 2;
        exp_b[0] = 8'h00;            // High byte always zero
        exp_b[1] = 8'h00;
        exp_b[1][STATUS_PROTO_ERR_BIT] = ref_err;
      end
      CCC_GETPID_DIR: begin
        n = 6;
        for (int i = 0; i < 6; i++) exp_b[i] = 8'(PID_VAL >> (40 - 8 * i));  // PID0 first
      end
      CCC_GETBCR_DIR: exp_b[0] = BCR_VAL;
      CCC_GETDCR_DIR: exp_b[0] = DCR_VAL;
      default:        exp_b[0] = 8'h00;
    endcase
    run_ccc(code, 1'b0, 0, n);
    check_result(code, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < n; i++) begin
      check_val($sformatf("o_sda_out byte %0d", i), 32'(rd_bytes[i]), 32'(exp_b[i]));
    end
    if (code == CCC_GETSTATUS_DIR) ref_err = 1'b0;   // Read clears sticky bit
  endtask

  task automatic begin_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s", name);
    end
  endtask

  initial begin
    sys_rst      = 1'b0;
    engine_en    = 1'b0;
    bit_stb      = 1'b0;
    bit_data     = 1'b0;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    ref_mwl      = MWL_VAL;
    ref_mrl      = MRL_VAL;
    ref_event_en = 4'hF;             // All events enabled out of reset
    ref_err      = 1'b0;
    ref_rstact   = 8'h00;
    void'($urandom(32'he3ab));
    repeat (16) @(posedge sys_clk);
    #1;
    sys_rst = 1'b1;
    repeat (2) @(posedge sys_clk);
    #1;

    begin_test();
    set_word(CCC_SETMWL_BC, 16'($urandom));
    get_check(CCC_GETMWL_DIR);
    set_word(CCC_SETMWL_DIR, 16'($urandom));
    get_check(CCC_GETMWL_DIR);
    end_test("setmwl_getmwl");

    begin_test();
    get_check(CCC_GETMRL_DIR);       // Reset value first
    set_word(CCC_SETMRL_BC, 16'($urandom));
    get_check(CCC_GETMRL_DIR);
    set_word(CCC_SETMRL_DIR, 16'($urandom));
    get_check(CCC_GETMRL_DIR);
    end_test("setmrl_getmrl");

    begin_test();
    check_val("o_event_en", 32'(event_en), 32'(ref_event_en));
    event_cmd(CCC_DISEC_BC, 8'h05);
    event_cmd(CCC_ENEC_DIR, 8'h04);
    event_cmd(CCC_DISEC_DIR, 8'hFA);  // Upper nibble ignored
    event_cmd(CCC_ENEC_BC, 8'h03);
    end_test("enec_disec");

    begin_test();
    get_check(CCC_GETPID_DIR);
    get_check(CCC_GETBCR_DIR);
    get_check(CCC_GETDCR_DIR);
    end_test("getpid_getbcr_getdcr");

    begin_test();
    run_ccc(CCC_GETSTATUS_DIR, 1'b1, 0, 0);
    check_result(CCC_GETSTATUS_DIR, 1'b0, 1'b0, 1'b1);
    ref_err = 1'b1;
    get_check(CCC_GETSTATUS_DIR);    // Error bit set, then cleared
    get_check(CCC_GETSTATUS_DIR);
    end_test("parity_error_status");

    begin_test();
    run_ccc(8'h7F, 1'b0, 0, 0);
    check_result(8'h7F, 1'b0, 1'b1, 1'b0);
    rstact_cmd(CCC_RSTACT_BC, 8'h5C);
    rstact_cmd(CCC_RSTACT_DIR, 8'h81);
    end_test("nack_rstact");

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ccc_target_top.f
verilog/ccc_target_pkg.sv
verilog/ccc_target_ctrl.sv
verilog/ccc_rx_deframer.sv
verilog/ccc_tx_framer.sv
verilog/ccc_target_regf.sv
verilog/ccc_target_top.sv
tests/ccc_target_asserts.sv
tests/tb_ccc_target_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_ccc_target_top -f ccc_target_top.f -o sim

# Assertion failures may stop the simulator, the log decides the result
./obj_dir/sim | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi
